//--- common/breakout_pkg.sv
// Geometry assumes a 160x120 frame buffer with 3-bit colour and coordinates below 256
package breakout_pkg;

	typedef logic [7:0] coord_t;
	typedef logic [2:0] colour_t;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	localparam int PADDLE_W = 16;
	localparam int PADDLE_H = 2;
	localparam coord_t PADDLE_X0 = 8'd76;
	localparam coord_t PADDLE_Y = 8'd110;
	localparam coord_t PADDLE_X_MAX = 8'd144;

	localparam coord_t BALL_X0 = 8'd80;
	localparam coord_t BALL_Y0 = 8'd108;

	localparam int BRICK_W = 8;
	localparam int BRICK_H = 2;
	localparam int BRICK_COUNT = 10;

	// Brick origins in index order
	localparam coord_t BRICK_X [BRICK_COUNT] = '{
		8'd15, 8'd45, 8'd75, 8'd105, 8'd135,
		8'd15, 8'd45, 8'd75, 8'd105, 8'd135
	};
	localparam coord_t BRICK_Y [BRICK_COUNT] = '{
		8'd30, 8'd30, 8'd30, 8'd30, 8'd30,
		8'd40, 8'd40, 8'd40, 8'd40, 8'd40
	};

	localparam int CEIL_STEP = 10;      // Field drop per miss
	localparam coord_t DEAD_LINE = 8'd108;

	localparam colour_t COL_BLACK = 3'b000;
	localparam colour_t COL_WHITE = 3'b111;
	localparam colour_t COL_GREEN = 3'b010;
	localparam colour_t COL_RED = 3'b100;

	typedef enum logic [3:0] {
		CLEAR,
		DRAW_PADDLE_INIT,
		DRAW_BALL_INIT,
		IDLE,
		ERASE_PADDLE,
		MOVE_PADDLE,
		DRAW_PADDLE,
		ERASE_BALL,
		STEP_BALL,
		DRAW_BALL,
		CHECK_BRICKS,
		DRAW_BRICKS,
		CHECK_WON,
		LOWER_CEIL,
		WON,
		DEAD
	} game_state_e;

endpackage

//--- logic/frame_tick.sv
// Frame strobe every FRAME_CYCLES clocks and FRAME_CYCLES must be at least 2
`timescale 1ns/1ps

module frame_tick #(
	parameter int FRAME_CYCLES = 833334
) (
	input  logic CLOCK_50,
	input  logic reset,
	output logic frame
);

	localparam int CNT_W = $clog2(FRAME_CYCLES);

	logic [CNT_W-1:0] count;

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			count <= CNT_W'(FRAME_CYCLES - 1);
			frame <= 1'b0;
		end else if (count == '0) begin
			count <= CNT_W'(FRAME_CYCLES - 1);  // Reload
			frame <= 1'b1;
		end else begin
			count <= count - 1'b1;
			frame <= 1'b0;
		end
	end

endmodule

//--- ball/ball_motion.sv
// Ball speed is one or two pixels per step and a miss needs a ball_start to clear
`timescale 1ns/1ps

module ball_motion (
	input  logic                 CLOCK_50,
	input  logic                 reset,
	input  logic                 ball_start,
	input  logic                 ball_step,
	input  breakout_pkg::coord_t paddle_x,
	input  logic                 brick_hit_apply,
	input  logic                 hit_odd,
	input  logic [3:0]           hit_count,
	output breakout_pkg::coord_t ball_x,
	output breakout_pkg::coord_t ball_y,
	output logic                 ball_missed
);

	logic                 left;     // x direction
	logic                 down;     // y direction
	logic [3:0]           bounce;
	logic [1:0]           speed;
	logic [8:0]           x_sum;
	breakout_pkg::coord_t nx;
	breakout_pkg::coord_t ny;
	logic                 flip_x;
	logic                 flip_y;
	logic                 on_paddle;

	assign speed = 2'd1 + {1'b0, bounce[0]};
	assign x_sum = {1'b0, ball_x} + {7'd0, speed};

	always_comb begin
		flip_x = 1'b0;
		flip_y = 1'b0;
		if (left) begin
			if (ball_x <= {6'd0, speed}) begin
				nx = '0;
				flip_x = 1'b1;
			end else begin
				nx = ball_x - {6'd0, speed};
			end
		end else begin
			if (x_sum >= 9'(breakout_pkg::SCREEN_W - 1)) begin
				nx = 8'(breakout_pkg::SCREEN_W - 1);
				flip_x = 1'b1;
			end else begin
				nx = x_sum[7:0];
			end
		end
		if (!down) begin
			if (ball_y <= {6'd0, speed}) begin
				ny = '0;
				flip_y = 1'b1;     // Ceiling
			end else begin
				ny = ball_y - {6'd0, speed};
			end
		end else begin
			ny = ball_y + {6'd0, speed};
			flip_y = on_paddle;
		end
	end

	assign on_paddle = (ny >= breakout_pkg::PADDLE_Y - 8'd1)
		&& (ny <= breakout_pkg::PADDLE_Y + 8'd1)
		&& (nx >= paddle_x)
		&& (nx <= paddle_x + 8'(breakout_pkg::PADDLE_W - 1));

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			ball_x <= breakout_pkg::BALL_X0;
			ball_y <= breakout_pkg::BALL_Y0;
			left <= 1'b0;
			down <= 1'b0;
			bounce <= '0;
			ball_missed <= 1'b0;
		end else if (ball_start) begin
			ball_x <= breakout_pkg::BALL_X0;  // Bounce count survives a miss
			ball_y <= breakout_pkg::BALL_Y0;
			left <= 1'b0;
			down <= 1'b0;
			ball_missed <= 1'b0;
		end else if (ball_step) begin
			ball_x <= nx;
			ball_y <= ny;
			left <= left ^ flip_x;
			down <= down ^ flip_y;
			ball_missed <= (ny >= breakout_pkg::SCREEN_H);
		end else if (brick_hit_apply) begin
			if (hit_odd)
				down <= ~down;
			bounce <= bounce + hit_count;  // Wraps at 16
		end
	end

endmodule

//--- blocks/block_field.sv
// Hit results are only valid in the cycle after brick_check
`timescale 1ns/1ps

module block_field (
	input  logic                                  CLOCK_50,
	input  logic                                  reset,
	input  logic                                  field_start,
	input  logic                                  brick_check,
	input  breakout_pkg::coord_t                  ball_x,
	input  breakout_pkg::coord_t                  ball_y,
	input  breakout_pkg::coord_t                  ceil_y,
	output logic [breakout_pkg::BRICK_COUNT-1:0] alive,
	output logic                                  hit_odd,
	output logic [3:0]                            hit_count,
	output logic                                  all_clear,
	output logic                                  reached_line
);

	logic [breakout_pkg::BRICK_COUNT-1:0] hit;
	logic [breakout_pkg::BRICK_COUNT-1:0] too_low;
	logic [3:0]                           n_hits;

	for (genvar i = 0; i < breakout_pkg::BRICK_COUNT; i++) begin : g_brick
		logic [8:0] top;     // Screen row of the brick
		logic [8:0] left_x;

		assign top = {1'b0, breakout_pkg::BRICK_Y[i]} + {1'b0, ceil_y};
		assign left_x = {1'b0, breakout_pkg::BRICK_X[i]};
		assign hit[i] = alive[i]
			&& ({1'b0, ball_y} >= top)
			&& ({1'b0, ball_y} < top + 9'(breakout_pkg::BRICK_H))
			&& ({1'b0, ball_x} >= left_x)
			&& ({1'b0, ball_x} < left_x + 9'(breakout_pkg::BRICK_W));
		// Looks one ceiling step ahead
		assign too_low[i] = alive[i] && (top + 9'(breakout_pkg::CEIL_STEP)
			+ 9'(breakout_pkg::BRICK_H) > {1'b0, breakout_pkg::DEAD_LINE});
	end

	always_comb begin
		n_hits = '0;
		for (int i = 0; i < breakout_pkg::BRICK_COUNT; i++) begin
			n_hits = n_hits + {3'd0, hit[i]};
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset || field_start)
			alive <= '1;
		else if (brick_check)
			alive <= alive & ~hit;
	end

	always_ff @(posedge CLOCK_50) begin
		if (brick_check) begin
			hit_odd <= ^hit;
			hit_count <= n_hits;
		end
	end

	assign all_clear = ~|alive;
	assign reached_line = |too_low;

endmodule

//--- logic/game_ctrl.sv
// Frame ticks outside IDLE are dropped and WON or DEAD hold until reset
`timescale 1ns/1ps

module game_ctrl (
	input  logic                                  CLOCK_50,
	input  logic                                  reset,
	input  logic                                  frame,
	input  logic                                  btn_left,
	input  logic                                  btn_right,
	input  breakout_pkg::coord_t                  ball_x,
	input  breakout_pkg::coord_t                  ball_y,
	input  logic                                  ball_missed,
	input  logic [breakout_pkg::BRICK_COUNT-1:0] alive,
	input  logic                                  all_clear,
	input  logic                                  reached_line,
	output logic                                  ball_start,
	output logic                                  ball_step,
	output breakout_pkg::coord_t                  paddle_x,
	output logic                                  field_start,
	output logic                                  brick_check,
	output logic                                  brick_hit_apply,
	output breakout_pkg::coord_t                  ceil_y,
	output breakout_pkg::coord_t                  pixel_x,
	output breakout_pkg::coord_t                  pixel_y,
	output breakout_pkg::colour_t                 pixel_colour,
	output logic                                  pixel_valid,
	output logic                                  won,
	output logic                                  dead
);

	localparam int PADDLE_LAST = breakout_pkg::PADDLE_W * breakout_pkg::PADDLE_H - 1;
	localparam int BRICKS_LAST = breakout_pkg::BRICK_COUNT * breakout_pkg::BRICK_W
		* breakout_pkg::BRICK_H - 1;

	breakout_pkg::game_state_e state;
	logic [14:0]               cnt;         // {row, col} while rastering
	logic [14:0]               raster_next;
	logic                      raster_last;
	logic                      paddle_last;
	logic [3:0]                brick_idx;
	breakout_pkg::coord_t      wr_x;
	breakout_pkg::coord_t      wr_y;
	breakout_pkg::colour_t     wr_col;
	logic                      wr_en;

	assign raster_next = (cnt[7:0] == 8'(breakout_pkg::SCREEN_W - 1))
		? {cnt[14:8] + 7'd1, 8'd0} : cnt + 15'd1;
	assign raster_last = (cnt[14:8] == 7'(breakout_pkg::SCREEN_H - 1))
		&& (cnt[7:0] == 8'(breakout_pkg::SCREEN_W - 1));
	assign paddle_last = (cnt == 15'(PADDLE_LAST));
	assign brick_idx = cnt[7:4];
	assign won = (state == breakout_pkg::WON);
	assign dead = (state == breakout_pkg::DEAD);

	always_comb begin
		wr_en = 1'b0;
		wr_x = cnt[7:0];
		wr_y = {1'b0, cnt[14:8]};
		wr_col = breakout_pkg::COL_BLACK;
		case (state)
			breakout_pkg::CLEAR: wr_en = 1'b1;
			breakout_pkg::WON, breakout_pkg::DEAD: begin
				wr_en = (cnt[14:8] < 7'(breakout_pkg::SCREEN_H));
				wr_col = won ? breakout_pkg::COL_GREEN : breakout_pkg::COL_RED;
			end
			breakout_pkg::DRAW_PADDLE_INIT, breakout_pkg::ERASE_PADDLE,
			breakout_pkg::DRAW_PADDLE: begin
				wr_en = 1'b1;
				wr_x = paddle_x + {4'd0, cnt[3:0]};
				wr_y = breakout_pkg::PADDLE_Y + {7'd0, cnt[4]};
				if (state != breakout_pkg::ERASE_PADDLE)
					wr_col = breakout_pkg::COL_WHITE;
			end
			breakout_pkg::DRAW_BALL_INIT, breakout_pkg::ERASE_BALL,
			breakout_pkg::DRAW_BALL: begin
				wr_en = (state != breakout_pkg::DRAW_BALL) || !ball_missed;
				wr_x = ball_x;
				wr_y = ball_y;
				if (state != breakout_pkg::ERASE_BALL)
					wr_col = breakout_pkg::COL_WHITE;
			end
			breakout_pkg::DRAW_BRICKS: begin
				wr_en = 1'b1;
				wr_x = breakout_pkg::BRICK_X[brick_idx] + {5'd0, cnt[2:0]};
				wr_y = breakout_pkg::BRICK_Y[brick_idx] + ceil_y + {7'd0, cnt[3]};
				wr_col = alive[brick_idx] ? breakout_pkg::COL_GREEN : breakout_pkg::COL_BLACK;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		pixel_x <= wr_x;
		pixel_y <= wr_y;
		pixel_colour <= wr_col;
	end

	always_ff @(posedge CLOCK_50) begin
		pixel_valid <= 1'b0;
		ball_start <= 1'b0;
		ball_step <= 1'b0;
		field_start <= 1'b0;
		brick_check <= 1'b0;
		brick_hit_apply <= 1'b0;
		if (reset) begin
			state <= breakout_pkg::CLEAR;
			cnt <= '0;
			paddle_x <= breakout_pkg::PADDLE_X0;
			ceil_y <= '0;
		end else begin
			pixel_valid <= wr_en;
			case (state)
				breakout_pkg::CLEAR: begin
					cnt <= raster_next;
					if (raster_last) begin
						cnt <= '0;
						ball_start <= 1'b1;
						field_start <= (ceil_y == '0);  // First round only
						paddle_x <= breakout_pkg::PADDLE_X0;
						state <= breakout_pkg::DRAW_PADDLE_INIT;
					end
				end
				breakout_pkg::DRAW_PADDLE_INIT: begin
					cnt <= paddle_last ? '0 : cnt + 15'd1;
					if (paddle_last)
						state <= breakout_pkg::DRAW_BALL_INIT;
				end
				breakout_pkg::DRAW_BALL_INIT: state <= breakout_pkg::IDLE;
				breakout_pkg::IDLE: begin
					if (frame)
						state <= breakout_pkg::ERASE_PADDLE;
				end
				breakout_pkg::ERASE_PADDLE: begin
					cnt <= paddle_last ? '0 : cnt + 15'd1;
					if (paddle_last)
						state <= breakout_pkg::MOVE_PADDLE;
				end
				breakout_pkg::MOVE_PADDLE: begin
					if (btn_right) begin
						if (paddle_x < breakout_pkg::PADDLE_X_MAX)
							paddle_x <= paddle_x + 8'd1;
					end else if (btn_left && paddle_x > 8'd0) begin
						paddle_x <= paddle_x - 8'd1;
					end
					state <= breakout_pkg::DRAW_PADDLE;
				end
				breakout_pkg::DRAW_PADDLE: begin
					cnt <= paddle_last ? '0 : cnt + 15'd1;
					if (paddle_last)
						state <= breakout_pkg::ERASE_BALL;
				end
				breakout_pkg::ERASE_BALL: begin
					ball_step <= 1'b1;
					state <= breakout_pkg::STEP_BALL;
				end
				breakout_pkg::STEP_BALL: state <= breakout_pkg::DRAW_BALL;  // Wait for new position
				breakout_pkg::DRAW_BALL: begin
					if (ball_missed) begin
						state <= breakout_pkg::LOWER_CEIL;
					end else begin
						brick_check <= 1'b1;
						state <= breakout_pkg::CHECK_BRICKS;
					end
				end
				breakout_pkg::CHECK_BRICKS: begin
					brick_hit_apply <= 1'b1;
					state <= breakout_pkg::DRAW_BRICKS;
				end
				breakout_pkg::DRAW_BRICKS: begin
					cnt <= cnt + 15'd1;
					if (cnt == 15'(BRICKS_LAST)) begin
						cnt <= '0;
						state <= breakout_pkg::CHECK_WON;
					end
				end
				breakout_pkg::CHECK_WON:
					state <= all_clear ? breakout_pkg::WON : breakout_pkg::IDLE;
				breakout_pkg::LOWER_CEIL: begin
					ceil_y <= ceil_y + 8'(breakout_pkg::CEIL_STEP);
					state <= reached_line ? breakout_pkg::DEAD : breakout_pkg::CLEAR;
				end
				breakout_pkg::WON, breakout_pkg::DEAD: begin
					if (cnt[14:8] < 7'(breakout_pkg::SCREEN_H))
						cnt <= raster_next;  // Single fill then hold
				end
			endcase
		end
	end

endmodule

//--- logic/breakout_top.sv
// Pixel writes have no back-pressure so the frame buffer must take one per clock
`timescale 1ns/1ps

module breakout_top #(
	parameter int FRAME_CYCLES = 833334
) (
	input  logic                  CLOCK_50,
	input  logic                  reset,
	input  logic                  btn_left,
	input  logic                  btn_right,
	output breakout_pkg::coord_t  pixel_x,
	output breakout_pkg::coord_t  pixel_y,
	output breakout_pkg::colour_t pixel_colour,
	output logic                  pixel_valid,
	output logic                  won,
	output logic                  dead
);

	logic                                  frame;
	logic                                  ball_start;
	logic                                  ball_step;
	logic                                  ball_missed;
	breakout_pkg::coord_t                  ball_x;
	breakout_pkg::coord_t                  ball_y;
	breakout_pkg::coord_t                  paddle_x;
	breakout_pkg::coord_t                  ceil_y;
	logic                                  field_start;
	logic                                  brick_check;
	logic                                  brick_hit_apply;
	logic [breakout_pkg::BRICK_COUNT-1:0] alive;
	logic                                  hit_odd;
	logic [3:0]                            hit_count;
	logic                                  all_clear;
	logic                                  reached_line;

	frame_tick #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) i_frame_tick (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.frame(frame)
	);

	ball_motion i_ball_motion (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.ball_start(ball_start),
		.ball_step(ball_step),
		.paddle_x(paddle_x),
		.brick_hit_apply(brick_hit_apply),
		.hit_odd(hit_odd),
		.hit_count(hit_count),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.ball_missed(ball_missed)
	);

	block_field i_block_field (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.field_start(field_start),
		.brick_check(brick_check),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.ceil_y(ceil_y),
		.alive(alive),
		.hit_odd(hit_odd),
		.hit_count(hit_count),
		.all_clear(all_clear),
		.reached_line(reached_line)
	);

	game_ctrl i_game_ctrl (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.frame(frame),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.ball_missed(ball_missed),
		.alive(alive),
		.all_clear(all_clear),
		.reached_line(reached_line),
		.ball_start(ball_start),
		.ball_step(ball_step),
		.paddle_x(paddle_x),
		.field_start(field_start),
		.brick_check(brick_check),
		.brick_hit_apply(brick_hit_apply),
		.ceil_y(ceil_y),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_colour(pixel_colour),
		.pixel_valid(pixel_valid),
		.won(won),
		.dead(dead)
	);

endmodule

//--- dv/tb_vectors.svh
// Button rows assume the fixed ball path of the first three rounds and a paddle that starts at 76
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int VEC_ROWS = 10;
localparam int NO_CHECK = 255;    // Paddle not checked at row end

// Columns are frames, btn_left, btn_right and expected paddle x after the row
int vectors [VEC_ROWS][4] = '{
	'{4, 0, 0, 76},       // Paddle at rest
	'{80, 1, 0, 0},       // Held left past the edge
	'{3, 1, 1, 3},        // Right wins over left
	'{130, 0, 1, 133},
	'{11, 0, 0, 76},      // First miss puts the paddle back
	'{80, 0, 1, 144},     // Held right past the edge
	'{4, 1, 1, 144},
	'{8, 0, 0, 76},       // Second miss
	'{40, 0, 1, 116},     // Paddle under the falling ball
	'{6000, 0, 0, NO_CHECK}  // Play on until won or dead
};

`endif

//--- dv/breakout_tb.sv
// Needs FRAME_CYCLES of 64 and a game that ends within the frames of the stimulus table
`timescale 1ns/1ps

module breakout_tb;

	`include "tb_vectors.svh"

	localparam int FRAME_CYCLES = 64;
	localparam int FRAME_DRAW = 230;    // Cycles of one frame's draw sequence
	localparam int CLEAR_LEN = 19200;

	logic                  CLOCK_50;
	logic                  reset;
	logic                  btn_left;
	logic                  btn_right;
	breakout_pkg::coord_t  pixel_x;
	breakout_pkg::coord_t  pixel_y;
	breakout_pkg::colour_t pixel_colour;
	logic                  pixel_valid;
	logic                  won;
	logic                  dead;

	int m_px;
	int m_bx;
	int m_by;
	int m_left;
	int m_down;
	int m_bounce;
	int m_ceil;
	int m_won;
	int m_dead;
	int m_alive [breakout_pkg::BRICK_COUNT];

	breakout_top #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) i_breakout_top (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.pixel_colour(pixel_colour),
		.pixel_valid(pixel_valid),
		.won(won),
		.dead(dead)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
			report_failure("Value check failed");
		end
	endtask

	// Next write in stream order, sampled away from the active edge
	task automatic expect_write(input int ex, input int ey, input int ec, input string phase);
		do @(negedge CLOCK_50); while (pixel_valid !== 1'b1);
		check({phase, " pixel_x"}, pixel_x, ex);
		check({phase, " pixel_y"}, pixel_y, ey);
		check({phase, " pixel_colour"}, pixel_colour, ec);
	endtask

	task automatic fill(input int colour, input string phase);
		for (int y = 0; y < breakout_pkg::SCREEN_H; y++)
			for (int x = 0; x < breakout_pkg::SCREEN_W; x++)
				expect_write(x, y, colour, phase);
	endtask

	task automatic paddle(input int colour, input string phase);
		for (int i = 0; i < 32; i++)
			expect_write(m_px + i % 16, 110 + i / 16, colour, phase);
	endtask

	task automatic restart();
		fill(breakout_pkg::COL_BLACK, "clear");
		m_px = 76;
		m_bx = 80;
		m_by = 108;
		m_left = 0;
		m_down = 0;
		paddle(breakout_pkg::COL_WHITE, "paddle init");
		expect_write(m_bx, m_by, breakout_pkg::COL_WHITE, "ball init");
	endtask

	task automatic step_ball();
		int spd;
		spd = 1 + m_bounce % 2;    // Odd bounce count doubles the speed
		if (m_left) begin
			if (m_bx <= spd) begin
				m_bx = 0;
				m_left = 0;
			end else
				m_bx = m_bx - spd;
		end else if (m_bx + spd >= 159) begin
			m_bx = 159;
			m_left = 1;
		end else
			m_bx = m_bx + spd;
		if (!m_down) begin
			if (m_by <= spd) begin
				m_by = 0;
				m_down = 1;
			end else
				m_by = m_by - spd;
		end else begin
			m_by = m_by + spd;
			if (m_by >= 109 && m_by <= 111 && m_bx >= m_px && m_bx <= m_px + 15)
				m_down = 0;    // Paddle bounce
		end
	endtask

	task automatic play_frame(input int l, input int r);
		int hits;
		int top;
		int reached;
		int left_any;
		paddle(breakout_pkg::COL_BLACK, "paddle erase");
		if (r && m_px < 144)
			m_px = m_px + 1;
		else if (!r && l && m_px > 0)
			m_px = m_px - 1;
		paddle(breakout_pkg::COL_WHITE, "paddle draw");
		expect_write(m_bx, m_by, breakout_pkg::COL_BLACK, "ball erase");
		step_ball();
		if (m_by >= 120) begin
			reached = 0;
			for (int b = 0; b < breakout_pkg::BRICK_COUNT; b++)
				if (m_alive[b] && breakout_pkg::BRICK_Y[b] + m_ceil + 12 > 108)
					reached = 1;
			m_ceil = m_ceil + 10;
			if (reached) begin
				m_dead = 1;
				fill(breakout_pkg::COL_RED, "dead fill");
			end else
				restart();
		end else begin
			expect_write(m_bx, m_by, breakout_pkg::COL_WHITE, "ball draw");
			hits = 0;
			for (int b = 0; b < breakout_pkg::BRICK_COUNT; b++) begin
				top = breakout_pkg::BRICK_Y[b] + m_ceil;
				if (m_alive[b] && m_by >= top && m_by <= top + 1
						&& m_bx >= breakout_pkg::BRICK_X[b] && m_bx < breakout_pkg::BRICK_X[b] + 8) begin
					m_alive[b] = 0;
					hits++;
				end
			end
			if (hits % 2)
				m_down = !m_down;
			m_bounce = (m_bounce + hits) % 16;
			left_any = 0;
			for (int b = 0; b < breakout_pkg::BRICK_COUNT; b++) begin
				left_any = left_any | m_alive[b];
				for (int i = 0; i < 16; i++)
					expect_write(breakout_pkg::BRICK_X[b] + i % 8,
						breakout_pkg::BRICK_Y[b] + m_ceil + i / 8,
						m_alive[b] ? breakout_pkg::COL_GREEN : breakout_pkg::COL_BLACK, "brick");
			end
			if (!left_any) begin
				m_won = 1;
				fill(breakout_pkg::COL_GREEN, "won fill");
			end
		end
	endtask

	initial begin
		int frames_total;
		int limit;
		int cycles;
		frames_total = 0;
		for (int r = 0; r < VEC_ROWS; r++)
			frames_total += vectors[r][0];
		limit = frames_total * (FRAME_CYCLES + FRAME_DRAW) + 30 * CLEAR_LEN;
		cycles = 0;
		forever begin
			@(posedge CLOCK_50);
			cycles++;
			if (cycles > limit)
				report_failure("Timeout: the game did not finish in time");
		end
	end

	initial begin
		reset = 1'b1;
		btn_left = 1'b0;
		btn_right = 1'b0;
		m_ceil = 0;
		m_bounce = 0;
		m_won = 0;
		m_dead = 0;
		for (int b = 0; b < breakout_pkg::BRICK_COUNT; b++)
			m_alive[b] = 1;
		repeat (3) @(posedge CLOCK_50);
		reset <= 1'b0;
		restart();
		for (int r = 0; r < VEC_ROWS; r++) begin
			@(posedge CLOCK_50);
			btn_left <= vectors[r][1];
			btn_right <= vectors[r][2];
			for (int f = 0; f < vectors[r][0] && !(m_won || m_dead); f++)
				play_frame(vectors[r][1], vectors[r][2]);
			if (!(m_won || m_dead) && vectors[r][3] != NO_CHECK)
				check("paddle_x", m_px, vectors[r][3]);
		end
		if (m_won || m_dead) begin
			check("won", won, m_won);
			check("dead", dead, m_dead);
			$display("Testbench passed");
		end else begin
			report_failure("The stimulus table ended before the game was won or lost");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+dv
common/breakout_pkg.sv
logic/frame_tick.sv
ball/ball_motion.sv
blocks/block_field.sv
logic/game_ctrl.sv
logic/breakout_top.sv
dv/breakout_tb.sv

//--- Bender.yml
package:
  name: breakout

sources:
  - common/breakout_pkg.sv
  - logic/frame_tick.sv
  - ball/ball_motion.sv
  - blocks/block_field.sv
  - logic/game_ctrl.sv
  - logic/breakout_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/breakout_tb.sv
